/* elev_cfg_pkg.sv */
// floor count and dwell defaults only, any build must keep NUM_FLOORS between 2 and MAX_FLOORS
package elev_cfg_pkg;

    //////////////////////////////
    // sizing
    //////////////////////////////

    // hard ceiling of the design, sets the width of a floor index
    localparam int MAX_FLOORS = 16;

    // floor index counted from zero
    typedef logic [$clog2(MAX_FLOORS)-1:0] floor_t;

    //////////////////////////////
    // build defaults
    //////////////////////////////

    // floors in the default building
    localparam int DEFAULT_NUM_FLOORS = 11;

    // cycles the doors stay open after each arrival
    localparam int DEFAULT_DWELL_CYCLES = 8;

endpackage

/* elev_ctrl_pkg.sv */
// dispatch encodings shared by the FSM and the testbench, the state enum is fixed at two bits
package elev_ctrl_pkg;

    // dispatch FSM states
    // idle waits for work, request holds move_req, release waits for ack low
    typedef enum logic [1:0] {
        ST_IDLE    = 2'b00,
        ST_REQUEST = 2'b01,
        ST_RELEASE = 2'b10,
        ST_DWELL   = 2'b11
    } dispatch_state_t;

    // travel direction handed to the car
    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } dir_t;

endpackage

/* request_if.sv */
// all strobes here last one cycle and the queue can never overflow, so it has no full flag
`timescale 1ns/1ns

interface request_if;
    import elev_cfg_pkg::*;

    // new floor from the button side
    logic   push;
    floor_t push_floor;

    // oldest pending floor
    floor_t head_floor;
    logic   empty;

    // dispatch takes the head
    logic   pop;

    // floor reached, its lamps go dark
    logic   served;
    floor_t served_floor;

    // halt empties the queue
    logic   flush;

    modport latch (output push, push_floor, flush, input served, served_floor);

    modport queue (input push, push_floor, pop, flush, output head_floor, empty);

    modport dispatch (input head_floor, empty, output pop, served, served_floor);

endinterface

/* request_latch.sv */
// takes at most one new floor per cycle, and a held button that loses priority waits for a later cycle
`timescale 1ns/1ns

module request_latch #(
    parameter int NUM_FLOORS = elev_cfg_pkg::DEFAULT_NUM_FLOORS
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic [NUM_FLOORS-1:0] floor_call_buttons,
    input  logic [NUM_FLOORS-1:0] panel_buttons,
    input  logic                  emergency_btn,
    input  logic                  power_switch,
    input  elev_cfg_pkg::floor_t  current_floor,
    request_if.latch              req,
    output logic [NUM_FLOORS-1:0] call_button_lights,
    output logic [NUM_FLOORS-1:0] panel_button_lights
);
    import elev_cfg_pkg::*;

    localparam logic [NUM_FLOORS-1:0] BIT0 = NUM_FLOORS'(1);

    logic                  halt;
    logic [NUM_FLOORS-1:0] floor_lit;
    logic [NUM_FLOORS-1:0] cur_onehot;
    logic [NUM_FLOORS-1:0] cand_panel;
    logic [NUM_FLOORS-1:0] cand_call;
    logic [NUM_FLOORS-1:0] pick_onehot;
    logic [NUM_FLOORS-1:0] served_mask;
    logic                  pick_valid;
    logic                  pick_panel;
    floor_t                pick_floor;

    //////////////////////////////
    // candidate presses
    //////////////////////////////

    assign halt       = !power_switch || emergency_btn;
    // a floor counts as lit when either of its lamps is on
    assign floor_lit  = call_button_lights | panel_button_lights;
    assign cur_onehot = BIT0 << current_floor;

    // car already there or floor already queued
    assign cand_panel = panel_buttons & ~floor_lit & ~cur_onehot;
    assign cand_call  = floor_call_buttons & ~floor_lit & ~cur_onehot;

    // panel beats call, lowest index wins
    always_comb begin
        pick_valid = 1'b0;
        pick_panel = 1'b0;
        pick_floor = '0;
        // scan downward so the lowest hit is written last
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (cand_call[i]) begin
                pick_valid = 1'b1;
                pick_floor = floor_t'(i);
            end
        end
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (cand_panel[i]) begin
                pick_valid = 1'b1;
                pick_panel = 1'b1;
                pick_floor = floor_t'(i);
            end
        end
    end

    assign pick_onehot = BIT0 << pick_floor;
    assign served_mask = req.served ? (BIT0 << req.served_floor) : '0;

    // queue side
    assign req.push       = pick_valid && !halt;
    assign req.push_floor = pick_floor;
    assign req.flush      = halt;

    //////////////////////////////
    // lamp registers
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else if (halt) begin
            // power loss or emergency drops every request
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            // served floor goes dark, new press lights its own lamp
            call_button_lights  <= (call_button_lights & ~served_mask)
                                 | ((req.push && !pick_panel) ? pick_onehot : '0);
            panel_button_lights <= (panel_button_lights & ~served_mask)
                                 | ((req.push && pick_panel) ? pick_onehot : '0);
        end
    end

endmodule

/* request_queue.sv */
// depth equals NUM_FLOORS and each floor sits in it at most once, so a push never finds it full
`timescale 1ns/1ns

module request_queue #(
    parameter int NUM_FLOORS = elev_cfg_pkg::DEFAULT_NUM_FLOORS
) (
    input  logic      clock,
    input  logic      reset_n,
    request_if.queue  req
);
    import elev_cfg_pkg::*;

    localparam int               PTR_W = $clog2(NUM_FLOORS);
    localparam int               CNT_W = $clog2(NUM_FLOORS + 1);
    localparam logic [PTR_W-1:0] LAST  = PTR_W'(NUM_FLOORS - 1);

    floor_t           mem [NUM_FLOORS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // flush wins over both strobes
    assign do_push = req.push && !req.flush;
    assign do_pop  = req.pop && (count != '0) && !req.flush;

    assign req.empty      = (count == '0);
    assign req.head_floor = mem[rd_ptr];

    // storage
    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= req.push_floor;
        end
    end

    //////////////////////////////
    // pointers and fill count
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (req.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // wrap at the last slot, depth need not be a power of two
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* door_timer.sv */
// dwell length is DWELL_CYCLES counted from the start edge and must be at least one cycle
`timescale 1ns/1ns

module door_timer #(
    parameter int DWELL_CYCLES = elev_cfg_pkg::DEFAULT_DWELL_CYCLES
) (
    input  logic clock,
    input  logic reset_n,
    input  logic start,
    input  logic cancel,
    output logic busy
);
    localparam int               CNT_W = $clog2(DWELL_CYCLES + 1);
    // the cycle after busy drops still belongs to the dwell
    localparam logic [CNT_W-1:0] LOAD  = CNT_W'(DWELL_CYCLES - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (cancel) begin
            // door close pressed
            count <= '0;
        end else if (start) begin
            count <= LOAD;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);

endmodule

/* dispatch_fsm.sv */
// car must raise move_ack only at target_floor, and a halt never aborts a handshake in flight
`timescale 1ns/1ns

module dispatch_fsm (
    input  logic                 clock,
    input  logic                 reset_n,
    request_if.dispatch          req,
    input  elev_cfg_pkg::floor_t current_floor,
    input  logic                 move_ack,
    input  logic                 emergency_btn,
    input  logic                 power_switch,
    input  logic                 door_open_btn,
    input  logic                 door_close_btn,
    input  logic                 dwell_busy,
    output logic                 dwell_start,
    output logic                 dwell_cancel,
    output logic                 move_req,
    output elev_cfg_pkg::floor_t target_floor,
    output elev_ctrl_pkg::dir_t  direction,
    output logic                 door_open_allowed,
    output logic                 door_close_allowed
);
    import elev_ctrl_pkg::*;

    dispatch_state_t state;
    dispatch_state_t state_next;
    logic            halt;
    logic            dispatch_go;
    logic            ack_seen;
    logic            served_q;

    assign halt        = !power_switch || emergency_btn;
    // idle, work pending and not halted
    assign dispatch_go = (state == ST_IDLE) && !req.empty && !halt;
    assign ack_seen    = (state == ST_REQUEST) && move_ack;

    //////////////////////////////
    // state sequencing
    //////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (dispatch_go) begin
                    state_next = ST_REQUEST;
                end
            end
            ST_REQUEST: begin
                // car is at the target
                if (move_ack) begin
                    state_next = ST_RELEASE;
                end
            end
            ST_RELEASE: begin
                if (!move_ack) begin
                    state_next = ST_DWELL;
                end
            end
            ST_DWELL: begin
                // close button cuts the dwell short
                if (door_close_btn || !dwell_busy) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state    <= ST_IDLE;
            served_q <= 1'b0;
        end else begin
            state    <= state_next;
            served_q <= ack_seen;
        end
    end

    // target and direction latched with the pop, stable for the handshake
    always_ff @(posedge clock) begin
        if (dispatch_go) begin
            target_floor <= req.head_floor;
            direction    <= (req.head_floor > current_floor) ? DIR_UP : DIR_DOWN;
        end
    end

    //////////////////////////////
    // outputs
    //////////////////////////////

    assign req.pop          = dispatch_go;
    assign req.served       = served_q;
    assign req.served_floor = target_floor;

    assign move_req     = (state == ST_REQUEST);
    assign dwell_start  = (state == ST_RELEASE) && !move_ack;
    assign dwell_cancel = (state == ST_DWELL) && door_close_btn;

    // doors only with the car stopped and power on, held open during dwell
    assign door_open_allowed  = power_switch
                              && ((state == ST_DWELL) || ((state == ST_IDLE) && door_open_btn));
    assign door_close_allowed = power_switch && door_close_btn
                              && ((state == ST_IDLE) || (state == ST_DWELL));

endmodule

/* elevator_ctrl_top.sv */
// NUM_FLOORS from 2 to 16, and current_floor and move_ack come from a car controller outside
`timescale 1ns/1ns

module elevator_ctrl_top #(
    parameter int NUM_FLOORS   = elev_cfg_pkg::DEFAULT_NUM_FLOORS,
    parameter int DWELL_CYCLES = elev_cfg_pkg::DEFAULT_DWELL_CYCLES
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic [NUM_FLOORS-1:0] floor_call_buttons,
    input  logic [NUM_FLOORS-1:0] panel_buttons,
    input  logic                  door_open_btn,
    input  logic                  door_close_btn,
    input  logic                  emergency_btn,
    input  logic                  power_switch,
    input  elev_cfg_pkg::floor_t  current_floor,
    input  logic                  move_ack,
    output logic                  move_req,
    output elev_cfg_pkg::floor_t  target_floor,
    output elev_ctrl_pkg::dir_t   direction,
    output logic [NUM_FLOORS-1:0] call_button_lights,
    output logic [NUM_FLOORS-1:0] panel_button_lights,
    output logic                  door_open_allowed,
    output logic                  door_close_allowed
);
    // dwell timer hookup
    logic dwell_start;
    logic dwell_cancel;
    logic dwell_busy;

    // queue and service traffic
    request_if req ();

    request_latch #(.NUM_FLOORS(NUM_FLOORS)) i_request_latch (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .current_floor       (current_floor),
        .req                 (req.latch),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    request_queue #(.NUM_FLOORS(NUM_FLOORS)) i_request_queue (
        .clock   (clock),
        .reset_n (reset_n),
        .req     (req.queue)
    );

    door_timer #(.DWELL_CYCLES(DWELL_CYCLES)) i_door_timer (
        .clock   (clock),
        .reset_n (reset_n),
        .start   (dwell_start),
        .cancel  (dwell_cancel),
        .busy    (dwell_busy)
    );

    dispatch_fsm i_dispatch_fsm (
        .clock              (clock),
        .reset_n            (reset_n),
        .req                (req.dispatch),
        .current_floor      (current_floor),
        .move_ack           (move_ack),
        .emergency_btn      (emergency_btn),
        .power_switch       (power_switch),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .dwell_busy         (dwell_busy),
        .dwell_start        (dwell_start),
        .dwell_cancel       (dwell_cancel),
        .move_req           (move_req),
        .target_floor       (target_floor),
        .direction          (direction),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

/* elevator_ctrl_props.sv */
// bound into dispatch_fsm, needs a simulator run with assertions enabled to report anything
`timescale 1ns/1ns

module elevator_ctrl_props (
    input logic                 clock,
    input logic                 reset_n,
    input logic                 move_req,
    input logic                 move_ack,
    input elev_cfg_pkg::floor_t target_floor
);

    //////////////////////////////
    // four-phase handshake
    //////////////////////////////

    // request held until the car answers
    req_waits_for_ack: assert property (@(posedge clock) disable iff (!reset_n)
        move_req && !move_ack |=> move_req)
        else $error("move_req dropped before move_ack rose");

    // ack may only drop once the request is gone
    ack_waits_for_req_low: assert property (@(posedge clock) disable iff (!reset_n)
        $fell(move_ack) |-> !move_req)
        else $error("move_ack dropped while move_req was high");

    // car needs a fixed destination
    target_stable: assert property (@(posedge clock) disable iff (!reset_n)
        move_req && $past(move_req) |-> $stable(target_floor))
        else $error("target_floor changed during a request");

endmodule

bind dispatch_fsm elevator_ctrl_props i_elevator_ctrl_props (
    .clock        (clock),
    .reset_n      (reset_n),
    .move_req     (move_req),
    .move_ack     (move_ack),
    .target_floor (target_floor)
);

/* tb_elevator_ctrl.sv */
// default build only and one driver process runs both the car model and the buttons on falling edges
`timescale 1ns/1ns

module tb_elevator_ctrl;
    import elev_cfg_pkg::*;
    import elev_ctrl_pkg::*;

    localparam int N       = DEFAULT_NUM_FLOORS;
    localparam int DWELL   = DEFAULT_DWELL_CYCLES;
    localparam int PERIOD  = 20;
    localparam int TIMEOUT = 2000;

    typedef logic [N-1:0] lamp_t;

    logic   clock;
    logic   reset_n;
    lamp_t  floor_call_buttons;
    lamp_t  panel_buttons;
    logic   door_open_btn;
    logic   door_close_btn;
    logic   emergency_btn;
    logic   power_switch;
    floor_t current_floor;
    logic   move_ack;
    logic   move_req;
    floor_t target_floor;
    dir_t   direction;
    lamp_t  call_button_lights;
    lamp_t  panel_button_lights;
    logic   door_open_allowed;
    logic   door_close_allowed;

    // reference state
    floor_t      model_q [$];
    lamp_t       model_call;
    lamp_t       model_panel;
    logic [19:0] lfsr_state;
    int          car_wait;
    int          errors;
    int          test_start;
    int          tests_run;
    int          tests_failed;
    int          dispatch_count;
    string       test_name;

    elevator_ctrl_top i_elevator_ctrl_top (.*);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    //////////////////////////////
    // random source and reference
    //////////////////////////////

    // x^20 + x^17 + 1 taps stepped once per bit
    function automatic int take_bits(input int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[19] ^ lfsr_state[16];
            lfsr_state = {lfsr_state[18:0], fb};
            v          = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    // one unlit non-current floor per cycle with panel first and lowest index
    function automatic void register_press(input lamp_t panel, input lamp_t call);
        lamp_t lit;
        int    pick;
        logic  from_panel;
        pick       = -1;
        from_panel = 1'b0;
        if (!power_switch || emergency_btn) begin
            model_call  = '0;
            model_panel = '0;
            model_q.delete();
            return;
        end
        lit = model_call | model_panel;
        for (int i = 0; i < N; i++) begin
            if (pick < 0 && call[i] && !lit[i] && i != int'(current_floor)) pick = i;
        end
        for (int i = 0; i < N; i++) begin
            if (!from_panel && panel[i] && !lit[i] && i != int'(current_floor)) begin
                pick       = i;
                from_panel = 1'b1;
            end
        end
        if (pick >= 0) begin
            model_q.push_back(floor_t'(pick));
            if (from_panel) model_panel[pick] = 1'b1;
            else model_call[pick] = 1'b1;
        end
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_floor(input string what, input floor_t exp, input floor_t act);
        if (exp !== act) begin
            $display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_dir(input string what, input dir_t exp, input dir_t act);
        if (exp !== act) begin
            $display("error %s %s: expected %s, actual %s", test_name, what, exp.name(),
                     act.name());
            errors++;
        end
    endtask

    task automatic check_lamps(input string what, input lamp_t exp, input lamp_t act);
        if (exp !== act) begin
            $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
            errors++;
        end
    endtask

    // handshake targets checked against the model queue a quarter period after the edge
    initial begin : compare_proc
        logic   req_prev;
        floor_t exp_floor;
        req_prev = 1'b0;
        forever begin
            @(posedge clock);
            #(PERIOD / 4);
            if (move_req && !req_prev) begin
                dispatch_count++;
                if (model_q.size() == 0) begin
                    $display("%s: move_req rose with no request pending", test_name);
                    errors++;
                end else begin
                    exp_floor = model_q.pop_front();
                    check_floor("target", exp_floor, target_floor);
                    check_dir("direction", (exp_floor > current_floor) ? DIR_UP : DIR_DOWN,
                              direction);
                end
            end
            // doors locked while the car is handling a move
            if ((move_req || move_ack) && (door_open_allowed || door_close_allowed)) begin
                $display("%s: door allowed during a move handshake", test_name);
                errors++;
            end
            req_prev = move_req;
        end
    end

    //////////////////////////////
    // driver tasks
    //////////////////////////////

    // car arrives 1 to 6 cycles after the request
    task automatic car_step();
        if (move_ack && !move_req) begin
            move_ack = 1'b0;
        end else if (move_req && !move_ack) begin
            if (car_wait < 0) car_wait = 1 + take_bits(3) % 6;
            car_wait--;
            if (car_wait == 0) begin
                current_floor             = target_floor;
                move_ack                  = 1'b1;
                car_wait                  = -1;
                model_call[target_floor]  = 1'b0;
                model_panel[target_floor] = 1'b0;
            end
        end
    endtask

    task automatic cycle(input lamp_t panel, input lamp_t call);
        @(negedge clock);
        car_step();
        panel_buttons      = panel;
        floor_call_buttons = call;
        register_press(panel, call);
    endtask

    task automatic set_halt(input logic emergency, input logic power);
        emergency_btn = emergency;
        power_switch  = power;
        // buttons still held are seen at the next edge
        register_press(panel_buttons, floor_call_buttons);
    endtask

    // sel 0 move_req, 1 move_ack, 2 door_open_allowed
    task automatic wait_until(input int sel, input logic level, input string what);
        int n;
        n = 0;
        while ((sel == 0 ? move_req : sel == 1 ? move_ack : door_open_allowed) !== level) begin
            if (n == TIMEOUT) begin
                $display("%s: timed out waiting for %s", test_name, what);
                errors++;
                return;
            end
            cycle('0, '0);
            n++;
        end
    endtask

    task automatic wait_all_served();
        int n;
        n = 0;
        while (model_q.size() != 0 || move_req || move_ack) begin
            if (n == TIMEOUT) begin
                $display("%s: timed out with requests still pending", test_name);
                errors++;
                return;
            end
            cycle('0, '0);
            n++;
        end
        repeat (3) cycle('0, '0);
        check_lamps("call lamps", model_call, call_button_lights);
        check_lamps("panel lamps", model_panel, panel_button_lights);
    endtask

    task automatic begin_test(input string name);
        test_name  = name;
        test_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_start) tests_failed++;
        $display("test %s: %s", test_name, (errors == test_start) ? "ok" : "FAILED");
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    initial begin : main_proc
        int     start;
        int     n;
        int     v;
        floor_t a;
        lamp_t  exp_panel;
        lamp_t  exp_call;
        reset_n = 1'b0;
        floor_call_buttons = '0;
        panel_buttons = '0;
        door_open_btn = 1'b0;
        door_close_btn = 1'b0;
        emergency_btn = 1'b0;
        power_switch = 1'b1;
        current_floor = '0;
        move_ack = 1'b0;
        model_call = '0;
        model_panel = '0;
        lfsr_state = 20'd72948;
        car_wait = -1;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        dispatch_count = 0;
        test_name = "reset";
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        begin_test("single_press");
        cycle(lamp_t'(1) << 7, '0);
        cycle('0, '0);
        check_lamps("panel lamp lit", model_panel, panel_button_lights);
        wait_all_served();
        end_test();

        begin_test("random_order");
        for (int i = 0; i < 20; i++) begin
            v = take_bits(2);
            a = floor_t'(take_bits(4) % N);
            if (v[0]) cycle(v[1] ? lamp_t'(1) << a : '0, v[1] ? '0 : lamp_t'(1) << a);
            else cycle('0, '0);
        end
        cycle(lamp_t'(1) << current_floor, lamp_t'(1) << current_floor);
        wait_all_served();
        end_test();

        begin_test("priority");
        for (int i = 0; i < 3; i++) begin
            cycle(lamp_t'(1) << 4 | lamp_t'(1) << 9, lamp_t'(1) << 2);
            if (i == 0) begin
                // lamps after the first edge only
                exp_panel = model_panel;
                exp_call  = model_call;
                cycle(lamp_t'(1) << 4 | lamp_t'(1) << 9, lamp_t'(1) << 2);
                check_lamps("first pick panel", exp_panel, panel_button_lights);
                check_lamps("first pick call", exp_call, call_button_lights);
            end
        end
        wait_all_served();
        end_test();

        begin_test("halt");
        cycle(lamp_t'(1) << 3, '0);
        cycle('0, lamp_t'(1) << 8);
        cycle(lamp_t'(1) << 10, '0);
        wait_until(0, 1'b1, "move_req");
        set_halt(1'b1, 1'b1);
        wait_until(0, 1'b0, "move_req low");
        wait_until(1, 1'b0, "move_ack low");
        start = dispatch_count;
        for (int i = 0; i < 30; i++) begin
            if (i == 15) set_halt(1'b0, 1'b0);
            cycle(lamp_t'(take_bits(N)), lamp_t'(take_bits(N)));
            check_lamps("lamps while halted", '0, call_button_lights | panel_button_lights);
        end
        if (dispatch_count != start) begin
            $display("error %s dispatches: expected %0d, actual %0d", test_name, start,
                     dispatch_count);
            errors++;
        end
        set_halt(1'b0, 1'b1);
        wait_all_served();
        end_test();

        begin_test("doors");
        a = current_floor;
        cycle(lamp_t'(1) << ((a + 3) % N), '0);
        cycle(lamp_t'(1) << ((a + 6) % N), '0);
        wait_until(1, 1'b1, "first arrival");
        wait_until(1, 1'b0, "first ack release");
        door_open_btn = 1'b1;
        n = 0;
        // doors stay allowed through the dwell until the next dispatch
        while (n < TIMEOUT) begin
            cycle('0, '0);
            n++;
            if (move_req) break;
            if (!door_open_allowed) begin
                $display("%s: door_open_allowed low between moves", test_name);
                errors++;
            end
        end
        if (!move_req) begin
            $display("%s: timed out waiting for the second dispatch", test_name);
            errors++;
        end
        door_open_btn = 1'b0;
        cycle(lamp_t'(1) << ((a + 9) % N), '0);
        wait_until(1, 1'b1, "second arrival");
        wait_until(1, 1'b0, "second ack release");
        door_close_btn = 1'b1;
        n = 0;
        while (!move_req && n < TIMEOUT) begin
            cycle('0, '0);
            n++;
            // car stopped with power on
            if (!move_req && !door_close_allowed) begin
                $display("%s: door_close_allowed low with the car stopped", test_name);
                errors++;
            end
        end
        door_close_btn = 1'b0;
        if (n >= DWELL) begin
            $display("%s: close button did not shorten the dwell, %0d cycles", test_name, n);
            errors++;
        end
        wait_all_served();
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* sim.f */
elev_cfg_pkg.sv
elev_ctrl_pkg.sv
request_if.sv
request_latch.sv
request_queue.sv
door_timer.sv
dispatch_fsm.sv
elevator_ctrl_top.sv
elevator_ctrl_props.sv
tb_elevator_ctrl.sv

/* Makefile */
# Verilator build and run of the elevator controller testbench

VERILATOR ?= verilator
TOP       ?= tb_elevator_ctrl
RTL_TOP   ?= elevator_ctrl_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
